// ==== bench/sha256_tb.sv ====
// Run from the project root; the test data must hold an all-zero message and at most 64 vectors
`timescale 1ns/1ns

module sha256_tb import sha256_pkg::*; ();

	localparam int CLK_HALF_NS  = 20;
	localparam int RESET_CYCLES = 10;
	localparam int PIPE_LATENCY = 65;

	logic    CLK;
	logic    RST;
	logic    block_valid_i;
	digest_t block_i;
	logic    block_ready_o;
	logic    digest_valid_o;
	digest_t digest_o;
	logic    digest_ready_i = 1'b0;

	logic [255:0] msg_mem [$];
	logic [255:0] exp_mem [$];
	int           pending_q [$];
	int           vector_total  = 0;
	int           zero_index    = -1;
	int           cur_index     = 0;
	int           sent_count    = 0;
	int           recv_count    = 0;
	int           max_in_flight = 0;
	int           error_count   = 0;
	logic         ready_random  = 1'b0;
	logic         saw_refusal   = 1'b0;
	logic [31:0]  lfsr_state    = 32'hd7fd_8425;

	sha256_core uut (
		.CLK           (CLK),
		.RST           (RST),
		.block_valid_i (block_valid_i),
		.block_i       (block_i),
		.block_ready_o (block_ready_o),
		.digest_valid_o(digest_valid_o),
		.digest_o      (digest_o),
		.digest_ready_i(digest_ready_i)
	);

	always #(CLK_HALF_NS) CLK = ~CLK;

	// Galois form of x^32 + x^22 + x^2 + x + 1
	function automatic logic [31:0] lfsr_next(input logic [31:0] state);
		if (state[0]) begin
			return (state >> 1) ^ 32'h8020_0003;
		end
		return state >> 1;
	endfunction

	function logic random_bit();
		lfsr_state = lfsr_next(lfsr_state);
		return lfsr_state[0];
	endfunction

	task automatic abort_run(input string reason);
		$display("%s", reason);
		$display("Something failed");
		$fatal(1, "Simulation stopped on the first error");
	endtask

	task automatic check_equal(input logic [255:0] actual, input logic [255:0] expected,
		input string what);
		if (actual !== expected) begin
			error_count++;
			abort_run($sformatf("FAILED at time %0t: %s, got %h, expected %h",
				$time, what, actual, expected));
		end
	endtask

	// Message and digest lines alternate, hash lines are comments
	task automatic load_vectors();
		int           fd;
		int           code;
		string        line;
		logic [255:0] value;
		logic [255:0] msg;
		logic         have_msg;
		have_msg = 1'b0;
		fd = $fopen("bench/sha256_testdata.txt", "r");
		if (fd == 0) begin
			abort_run("Could not open bench/sha256_testdata.txt");
		end
		while (!$feof(fd)) begin
			code = $fgets(line, fd);
			if (code <= 0 || line.getc(0) == "#") begin
				continue;
			end
			code = $sscanf(line, "%h", value);
			if (code != 1) begin
				continue;
			end
			if (have_msg) begin
				msg_mem.push_back(msg);
				exp_mem.push_back(value);
				if (msg == '0) begin
					zero_index = msg_mem.size() - 1;
				end
				have_msg = 1'b0;
			end else begin
				msg = value;
				have_msg = 1'b1;
			end
		end
		$fclose(fd);
		if (have_msg || msg_mem.size() == 0 || zero_index < 0) begin
			abort_run("Test data is empty, unpaired or lacks the all-zero message");
		end
		vector_total = msg_mem.size();
	endtask

	// Called on a falling edge, returns on the falling edge after acceptance
	task automatic send_vector(input int idx, input logic random_gap);
		int gap;
		int target;
		gap = 0;
		if (random_gap) begin
			for (int b = 0; b < 2; b++) begin
				gap = gap * 2 + int'(random_bit());
			end
		end
		repeat (gap) @(negedge CLK);
		target = sent_count + 1;
		cur_index = idx;
		block_i = msg_mem[idx];
		block_valid_i = 1'b1;
		do begin
			@(negedge CLK);
		end while (sent_count < target);
		block_valid_i = 1'b0;
	endtask

	// Outstanding digests get a cycle budget each
	task automatic wait_for_drain(input string test_name);
		int budget;
		budget = (PIPE_LATENCY + 64) * (pending_q.size() + 1);
		while (pending_q.size() != 0 && budget > 0) begin
			@(negedge CLK);
			budget--;
		end
		check_equal(256'(recv_count), 256'(sent_count),
			{test_name, ": digests received against messages sent"});
		check_equal(256'(digest_valid_o), 256'(0),
			{test_name, ": output still valid after the last digest"});
	endtask

	// Scoreboard pops before it pushes, so one process owns the queue
	always @(posedge CLK) begin : scoreboard
		int idx;
		if (RST) begin
			if (digest_valid_o && digest_ready_i) begin
				if (pending_q.size() == 0) begin
					abort_run("A digest came out while no message was outstanding");
				end else begin
					idx = pending_q.pop_front();
					check_equal(digest_o, exp_mem[idx], $sformatf("digest of vector %0d", idx));
					recv_count++;
				end
			end
			if (block_valid_i && block_ready_o) begin
				pending_q.push_back(cur_index);
				sent_count++;
			end
			if (block_valid_i && !block_ready_o) begin
				saw_refusal = 1'b1;
			end
			if (pending_q.size() > max_in_flight) begin
				max_in_flight = pending_q.size();
			end
		end
	end

	always @(negedge CLK) begin : sink_drive
		logic r0;
		logic r1;
		if (ready_random) begin
			r0 = random_bit();
			r1 = random_bit();
			// Ready about one cycle in four
			digest_ready_i = r0 & r1;
		end else begin
			digest_ready_i = 1'b1;
		end
	end

	initial begin : watchdog
		longint limit_ns;
		wait (vector_total > 0);
		limit_ns = longint'(vector_total) * (PIPE_LATENCY + 64) * (2 * CLK_HALF_NS) * 4;
		#(limit_ns);
		abort_run("Timeout: the tests did not finish within the watchdog limit");
	end

	initial begin : main
		int latency;
		int min_depth;
		CLK = 1'b0;
		RST = 1'b0;
		block_valid_i = 1'b0;
		block_i = '0;
		load_vectors();
		repeat (RESET_CYCLES) @(negedge CLK);
		RST = 1'b1;
		@(negedge CLK);

		// Idle after reset
		check_equal(256'(digest_valid_o), 256'(0), "digest_valid_o after reset");
		check_equal(256'(block_ready_o), 256'(1), "block_ready_o after reset");

		// Lone message and its latency
		send_vector(zero_index, 1'b0);
		latency = 0;
		while (!digest_valid_o) begin
			@(negedge CLK);
			latency++;
		end
		check_equal(256'(latency), 256'(PIPE_LATENCY), "latency of a lone message");
		wait_for_drain("single message");

		// Back-to-back burst, all in flight at once
		max_in_flight = 0;
		foreach (msg_mem[i]) begin
			send_vector(i, 1'b0);
		end
		wait_for_drain("burst");
		min_depth = (vector_total < 64) ? vector_total : 64;
		check_equal(256'(max_in_flight >= min_depth), 256'(1), "messages in flight in the burst");

		foreach (msg_mem[i]) begin
			send_vector(i, 1'b1);
		end
		wait_for_drain("random gaps");

		// Slow sink; a second burst meets a full FIFO
		ready_random = 1'b1;
		saw_refusal = 1'b0;
		foreach (msg_mem[i]) begin
			send_vector(i, 1'b0);
		end
		while (!digest_valid_o) begin
			@(negedge CLK);
		end
		foreach (msg_mem[i]) begin
			send_vector(vector_total - 1 - i, 1'b0);
		end
		wait_for_drain("back-pressure");
		ready_random = 1'b0;
		check_equal(256'(saw_refusal), 256'(1), "input refused while the sink stalled");

		if (error_count == 0) begin
			$display("Everything OK");
			$finish;
		end else begin
			abort_run("Checks reported errors");
		end
	end

endmodule

// ==== bench/sha256_testdata.txt ====
# Pairs of lines: a 256-bit message (first byte leftmost), then its SHA-256 digest
# Every value is 64 hex digits; each message fills exactly one padded block
0000000000000000000000000000000000000000000000000000000000000000
66687aadf862bd776c8fc18b8e9f8e20089714856ee233b3902a591d0d5f2925
e3b0c44298fc1c149afbf4c8996fb92427ae41e4649b934ca495991b7852b855
5df6e0e2761359d30a8275058e299fcc0381534545f55cf43e41983f5d4c9456
ba7816bf8f01cfea414140de5dae2223b00361a396177a9cb410ff61f20015ad
4f8b42c22dd3729b519ba6f68d2da7cc5b2d606d05daed5ad5128cc03e6c6358
2cf24dba5fb0a30e26e83b2ac5b9e29e1b161e5c1fa7425e73043362938b9824
9595c9df90075148eb06860365df33584b75bff782a510c6cd4883a419833d50
2cf24dba5fb0a30e26e83b2ac5b9e29e1b161e5c1fa7425e73043362938b9824
9595c9df90075148eb06860365df33584b75bff782a510c6cd4883a419833d50
0000000000000000000000000000000000000000000000000000000000000000
66687aadf862bd776c8fc18b8e9f8e20089714856ee233b3902a591d0d5f2925
ba7816bf8f01cfea414140de5dae2223b00361a396177a9cb410ff61f20015ad
4f8b42c22dd3729b519ba6f68d2da7cc5b2d606d05daed5ad5128cc03e6c6358
e3b0c44298fc1c149afbf4c8996fb92427ae41e4649b934ca495991b7852b855
5df6e0e2761359d30a8275058e299fcc0381534545f55cf43e41983f5d4c9456
ba7816bf8f01cfea414140de5dae2223b00361a396177a9cb410ff61f20015ad
4f8b42c22dd3729b519ba6f68d2da7cc5b2d606d05daed5ad5128cc03e6c6358
2cf24dba5fb0a30e26e83b2ac5b9e29e1b161e5c1fa7425e73043362938b9824
9595c9df90075148eb06860365df33584b75bff782a510c6cd4883a419833d50
e3b0c44298fc1c149afbf4c8996fb92427ae41e4649b934ca495991b7852b855
5df6e0e2761359d30a8275058e299fcc0381534545f55cf43e41983f5d4c9456
0000000000000000000000000000000000000000000000000000000000000000
66687aadf862bd776c8fc18b8e9f8e20089714856ee233b3902a591d0d5f2925

// ==== build.f ====
+incdir+source
source/sha256_pkg.sv
source/sha256_round_stage.sv
source/sha256_pipeline.sv
source/sha256_result_fifo.sv
source/sha256_core.sv
bench/sha256_tb.sv

// ==== run.sh ====
#!/bin/bash
# Compile and run the SHA-256 core testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal \
	--top-module sha256_tb -f build.f --Mdir obj_dir -o sha256_sim

# The pipe keeps going so that the log search decides the result
./obj_dir/sha256_sim | tee sim.log

if grep -q "Something failed" sim.log; then
	echo "Simulation reported a failure, see sim.log"
	exit 1
fi

if ! grep -q "Everything OK" sim.log; then
	echo "Simulation ended without a pass report, see sim.log"
	exit 1
fi

echo "Simulation passed"

// ==== source/sha256_core.sv ====
// SHA-256 of one 32-byte big-endian message per transfer; digests leave in arrival order
`timescale 1ns/1ns
`include "sha256_params.svh"

module sha256_core import sha256_pkg::*; (
	input  logic    CLK,
	input  logic    RST,
	input  logic    block_valid_i,
	input  digest_t block_i,
	output logic    block_ready_o,
	output logic    digest_valid_o,
	output digest_t digest_o,
	input  logic    digest_ready_i
);

	logic    res_valid;
	digest_t res_digest;
	logic    res_ready;

	// Round pipeline
	sha256_pipeline u_pipeline (
		.CLK          (CLK),
		.RST          (RST),
		.block_valid_i(block_valid_i),
		.block_i      (block_i),
		.block_ready_o(block_ready_o),
		.res_valid_o  (res_valid),
		.res_digest_o (res_digest),
		.res_ready_i  (res_ready)
	);

	// Absorbs short sink stalls
	sha256_result_fifo #(
		.payload_t(digest_t),
		.DEPTH    (`SHA256_FIFO_DEPTH)
	) u_fifo (
		.CLK       (CLK),
		.RST       (RST),
		.wr_valid_i(res_valid),
		.wr_data_i (res_digest),
		.wr_ready_o(res_ready),
		.rd_valid_o(digest_valid_o),
		.rd_data_o (digest_o),
		.rd_ready_i(digest_ready_i)
	);

endmodule

// ==== source/sha256_params.svh ====
// Fixed one-block padding: only 256-bit messages hash correctly with these pad and length words
`ifndef SHA256_PARAMS_SVH
`define SHA256_PARAMS_SVH

// Word and pipeline geometry
`define SHA256_WORD_W 32
`define SHA256_ROUNDS 64

// Result buffer depth
`define SHA256_FIFO_DEPTH 4

// H0 in the top word, H7 in the bottom word
`define SHA256_IV 256'h6a09e667_bb67ae85_3c6ef372_a54ff53a_510e527f_9b05688c_1f83d9ab_5be0cd19

// Padding after a 256-bit message
`define SHA256_PAD_WORD 32'h8000_0000
`define SHA256_LEN_WORD 32'd256

`endif

// ==== source/sha256_pipeline.sv ====
// 64 unrolled rounds plus a feed-forward register; only 256-bit single-block messages
`timescale 1ns/1ns
`include "sha256_params.svh"

module sha256_pipeline import sha256_pkg::*; (
	input  logic    CLK,
	input  logic    RST,
	input  logic    block_valid_i,
	input  digest_t block_i,
	output logic    block_ready_o,
	output logic    res_valid_o,
	output digest_t res_digest_o,
	input  logic    res_ready_i
);

	localparam digest_t IV = `SHA256_IV;

	logic    stage_valid  [`SHA256_ROUNDS+1];
	digest_t stage_state  [`SHA256_ROUNDS+1];
	window_t stage_window [`SHA256_ROUNDS+1];
	window_t block_window;
	logic    advance;

	// Message word 0 is the top word of block_i
	always_comb begin
		for (int i = 0; i < 8; i++) begin
			block_window[i] = block_i[7 - i];
		end
		block_window[8] = `SHA256_PAD_WORD;
		for (int i = 9; i < 15; i++) begin
			block_window[i] = '0;
		end
		block_window[15] = `SHA256_LEN_WORD;
	end

	// Whole pipeline moves together
	assign advance       = !res_valid_o || res_ready_i;
	assign block_ready_o = advance;

	assign stage_valid[0]  = block_valid_i;
	assign stage_state[0]  = IV;
	assign stage_window[0] = block_window;

	for (genvar r = 0; r < `SHA256_ROUNDS; r++) begin : g_round
		sha256_round_stage #(
			.ROUND(r)
		) u_stage (
			.CLK      (CLK),
			.RST      (RST),
			.advance_i(advance),
			.valid_i  (stage_valid[r]),
			.state_i  (stage_state[r]),
			.window_i (stage_window[r]),
			.valid_o  (stage_valid[r+1]),
			.state_o  (stage_state[r+1]),
			.window_o (stage_window[r+1])
		);
	end

	always_ff @(posedge CLK or negedge RST) begin
		if (!RST) begin
			res_valid_o <= 1'b0;
		end else if (advance) begin
			res_valid_o <= stage_valid[`SHA256_ROUNDS];
		end
	end

	// Feed-forward of the initial hash value
	always_ff @(posedge CLK) begin
		if (advance && stage_valid[`SHA256_ROUNDS]) begin
			for (int i = 0; i < 8; i++) begin
				res_digest_o[i] <= stage_state[`SHA256_ROUNDS][i] + IV[i];
			end
		end
	end

	// A refused result waits unchanged for the buffer
	a_no_loss: assert property (@(posedge CLK) disable iff (!RST)
		res_valid_o && !res_ready_i |=> res_valid_o && $stable(res_digest_o));

endmodule

// ==== source/sha256_pkg.sv ====
// SHA-256 word types, round constants and bit functions; words are big-endian, word 7 on top
`include "sha256_params.svh"

package sha256_pkg;

	typedef logic [`SHA256_WORD_W-1:0] word_t;

	// Index 7 is A (or H0), index 0 is H (or H7)
	typedef word_t [7:0] digest_t;

	// Index 0 is the word the next round consumes
	typedef word_t [15:0] window_t;

	localparam word_t sha256_k [`SHA256_ROUNDS] = '{
		32'h428a2f98, 32'h71374491, 32'hb5c0fbcf, 32'he9b5dba5,
		32'h3956c25b, 32'h59f111f1, 32'h923f82a4, 32'hab1c5ed5,
		32'hd807aa98, 32'h12835b01, 32'h243185be, 32'h550c7dc3,
		32'h72be5d74, 32'h80deb1fe, 32'h9bdc06a7, 32'hc19bf174,
		32'he49b69c1, 32'hefbe4786, 32'h0fc19dc6, 32'h240ca1cc,
		32'h2de92c6f, 32'h4a7484aa, 32'h5cb0a9dc, 32'h76f988da,
		32'h983e5152, 32'ha831c66d, 32'hb00327c8, 32'hbf597fc7,
		32'hc6e00bf3, 32'hd5a79147, 32'h06ca6351, 32'h14292967,
		32'h27b70a85, 32'h2e1b2138, 32'h4d2c6dfc, 32'h53380d13,
		32'h650a7354, 32'h766a0abb, 32'h81c2c92e, 32'h92722c85,
		32'ha2bfe8a1, 32'ha81a664b, 32'hc24b8b70, 32'hc76c51a3,
		32'hd192e819, 32'hd6990624, 32'hf40e3585, 32'h106aa070,
		32'h19a4c116, 32'h1e376c08, 32'h2748774c, 32'h34b0bcb5,
		32'h391c0cb3, 32'h4ed8aa4a, 32'h5b9cca4f, 32'h682e6ff3,
		32'h748f82ee, 32'h78a5636f, 32'h84c87814, 32'h8cc70208,
		32'h90befffa, 32'ha4506ceb, 32'hbef9a3f7, 32'hc67178f2
	};

	// Rotate right by a constant amount
	function automatic word_t rotr(word_t x, int unsigned n);
		return (x >> n) | (x << (`SHA256_WORD_W - n));
	endfunction

	// Choose bits of y or z under x
	function automatic word_t ch(word_t x, word_t y, word_t z);
		return (x & y) ^ (~x & z);
	endfunction

	// Bitwise majority
	function automatic word_t maj(word_t x, word_t y, word_t z);
		return (x & y) ^ (x & z) ^ (y & z);
	endfunction

	function automatic word_t big_sigma0(word_t x);
		return rotr(x, 2) ^ rotr(x, 13) ^ rotr(x, 22);
	endfunction

	function automatic word_t big_sigma1(word_t x);
		return rotr(x, 6) ^ rotr(x, 11) ^ rotr(x, 25);
	endfunction

	// Schedule mixes end in a plain shift, not a rotate
	function automatic word_t small_sigma0(word_t x);
		return rotr(x, 7) ^ rotr(x, 18) ^ (x >> 3);
	endfunction

	function automatic word_t small_sigma1(word_t x);
		return rotr(x, 17) ^ rotr(x, 19) ^ (x >> 10);
	endfunction

endpackage

// ==== source/sha256_result_fifo.sv ====
// Circular buffer with first-word visibility one cycle after the write; full accepts with a read
`timescale 1ns/1ns

module sha256_result_fifo import sha256_pkg::*; #(
	parameter type payload_t = digest_t,
	parameter int  DEPTH     = 4
) (
	input  logic     CLK,
	input  logic     RST,
	input  logic     wr_valid_i,
	input  payload_t wr_data_i,
	output logic     wr_ready_o,
	output logic     rd_valid_o,
	output payload_t rd_data_o,
	input  logic     rd_ready_i
);

	localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
	localparam int CNT_W = $clog2(DEPTH + 1);

	payload_t         mem [DEPTH];
	logic [PTR_W-1:0] wr_ptr;
	logic [PTR_W-1:0] rd_ptr;
	logic [CNT_W-1:0] count;
	logic             wr_fire;
	logic             rd_fire;

	// Wrap for any depth
	function automatic logic [PTR_W-1:0] ptr_inc(logic [PTR_W-1:0] ptr);
		if (ptr == PTR_W'(DEPTH - 1)) begin
			return '0;
		end
		return ptr + 1'b1;
	endfunction

	assign rd_valid_o = (count != '0);
	assign wr_ready_o = (count != CNT_W'(DEPTH)) || rd_ready_i;
	assign wr_fire    = wr_valid_i && wr_ready_o;
	assign rd_fire    = rd_valid_o && rd_ready_i;
	assign rd_data_o  = mem[rd_ptr];

	always_ff @(posedge CLK or negedge RST) begin
		if (!RST) begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			count  <= '0;
		end else begin
			if (wr_fire) begin
				wr_ptr <= ptr_inc(wr_ptr);
			end
			if (rd_fire) begin
				rd_ptr <= ptr_inc(rd_ptr);
			end
			if (wr_fire && !rd_fire) begin
				count <= count + 1'b1;
			end else if (rd_fire && !wr_fire) begin
				count <= count - 1'b1;
			end
		end
	end

	always_ff @(posedge CLK) begin
		if (wr_fire) begin
			mem[wr_ptr] <= wr_data_i;
		end
	end

	// Write into a full buffer only alongside a read
	a_no_overflow: assert property (@(posedge CLK) disable iff (!RST)
		wr_fire && wr_ptr == rd_ptr && count != '0 |-> rd_fire);

	// Read never from an empty buffer
	a_no_underflow: assert property (@(posedge CLK) disable iff (!RST)
		rd_fire |-> wr_ptr != rd_ptr || count == CNT_W'(DEPTH));

endmodule

// ==== source/sha256_round_stage.sv ====
// One registered SHA-256 round; state_o and window_o are undefined while valid_o is low
`timescale 1ns/1ns

module sha256_round_stage import sha256_pkg::*; #(
	parameter int ROUND = 0
) (
	input  logic    CLK,
	input  logic    RST,
	input  logic    advance_i,
	input  logic    valid_i,
	input  digest_t state_i,
	input  window_t window_i,
	output logic    valid_o,
	output digest_t state_o,
	output window_t window_o
);

	word_t   temp1;
	word_t   temp2;
	word_t   w_next;
	digest_t state_next;
	window_t window_next;

	// Compression round on A..H
	always_comb begin
		temp1 = state_i[0] + big_sigma1(state_i[3]) + ch(state_i[3], state_i[2], state_i[1])
			+ sha256_k[ROUND] + window_i[0];
		temp2 = big_sigma0(state_i[7]) + maj(state_i[7], state_i[6], state_i[5]);
		state_next = {temp1 + temp2, state_i[7:5], state_i[4] + temp1, state_i[3:1]};
	end

	// W[t+16] from W[t], W[t+1], W[t+9] and W[t+14]
	always_comb begin
		w_next = small_sigma1(window_i[14]) + window_i[9]
			+ small_sigma0(window_i[1]) + window_i[0];
		window_next = {w_next, window_i[15:1]};
	end

	always_ff @(posedge CLK or negedge RST) begin
		if (!RST) begin
			valid_o <= 1'b0;
		end else if (advance_i) begin
			valid_o <= valid_i;
		end
	end

	// Bubbles leave the payload untouched
	always_ff @(posedge CLK) begin
		if (advance_i && valid_i) begin
			state_o  <= state_next;
			window_o <= window_next;
		end
	end

	// A stalled stage keeps its contents
	a_hold_on_stall: assert property (@(posedge CLK) disable iff (!RST)
		!advance_i |=> $stable(valid_o) && $stable(state_o) && $stable(window_o));

endmodule
